//--- Makefile
# Verilator build and run of the line bridge testbench

.PHONY: help test clean

help:
	@echo "make test    build the testbench with Verilator and run it"
	@echo "make clean   remove the Verilator build directory"
	@echo "make help    show this list"

test:
	verilator --binary --timing --top-module tb_line_bridge -f flist.f \
		--Mdir obj_dir -o sim_line_bridge
	./obj_dir/sim_line_bridge

clean:
	rm -rf obj_dir

//--- dv/axi_memory_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_memory_model (
    input  wire                                    aclk,
    input  wire line_bridge_pkg::axi_id_t          i_ar_id,
    input  wire line_bridge_pkg::addr_t            i_ar_addr,
    input  wire [line_bridge_pkg::LEN_BITS-1:0]    i_ar_len,
    input  wire [line_bridge_pkg::SIZE_BITS-1:0]   i_ar_size,
    input  wire [line_bridge_pkg::BURST_BITS-1:0]  i_ar_burst,
    input  wire                                    i_ar_valid,
    output logic                                   o_ar_ready,
    output line_bridge_pkg::axi_id_t               o_r_id,
    output line_bridge_pkg::beat_t                 o_r_data,
    output logic                                   o_r_last,
    output logic                                   o_r_valid,
    input  wire                                    i_r_ready,
    input  wire line_bridge_pkg::addr_t            i_aw_addr,
    input  wire [line_bridge_pkg::LEN_BITS-1:0]    i_aw_len,
    input  wire [line_bridge_pkg::SIZE_BITS-1:0]   i_aw_size,
    input  wire [line_bridge_pkg::BURST_BITS-1:0]  i_aw_burst,
    input  wire                                    i_aw_valid,
    output logic                                   o_aw_ready,
    input  wire line_bridge_pkg::beat_t            i_w_data,
    input  wire                                    i_w_last,
    input  wire                                    i_w_valid,
    output logic                                   o_w_ready,
    output logic                                   o_b_valid,
    input  wire                                    i_b_ready,
    output logic                                   o_error
);

    line_bridge_pkg::beat_t   mem [4096];     // 16 KiB of word storage
    line_bridge_pkg::axi_id_t rid_q [$];      // accepted ARs, in order
    line_bridge_pkg::addr_t   raddr_q [$];
    line_bridge_pkg::addr_t   r_addr;
    line_bridge_pkg::addr_t   w_addr;
    int                       r_beat;
    int                       w_beat;
    logic                     r_busy;
    logic                     r_hs;
    logic                     w_hs;
    logic                     b_pend;         // last beat seen, response owed

    function automatic line_bridge_pkg::beat_t fill_word(line_bridge_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic logic [11:0] word_index(line_bridge_pkg::addr_t a);
        return a[13:2];
    endfunction

    task automatic protocol_error(string what);
        $display("memory model: %s at %0t", what, $time);
        o_error = 1'b1;
    endtask

    initial
    begin
        {o_ar_ready, o_r_valid, o_r_last, o_aw_ready, o_w_ready, o_b_valid, o_error} = '0;
        o_r_id   = '0;
        o_r_data = '0;
        r_addr   = '0;
        w_addr   = '0;
        r_beat   = 0;
        w_beat   = 0;
        r_busy   = 1'b0;
        b_pend   = 1'b0;
        for (int i = 0; i < 4096; i++)
            mem[12'(i)] = fill_word(line_bridge_pkg::addr_t'(i * 4));
        forever
        begin
            @(posedge aclk);
            r_hs = o_r_valid && i_r_ready;     // values before the edge updates
            w_hs = i_w_valid && o_w_ready;
            if (i_ar_valid && o_ar_ready)
            begin
                if (i_ar_len != line_bridge_pkg::BURST_LEN
                    || i_ar_size != line_bridge_pkg::BURST_SIZE
                    || i_ar_burst != line_bridge_pkg::BURST_INCR)
                    protocol_error("AR length, size or burst differs from the line format");
                rid_q.push_back(i_ar_id);
                raddr_q.push_back(i_ar_addr);
            end
            if (i_aw_valid && o_aw_ready)
            begin
                if (i_aw_len != line_bridge_pkg::BURST_LEN
                    || i_aw_size != line_bridge_pkg::BURST_SIZE
                    || i_aw_burst != line_bridge_pkg::BURST_INCR)
                    protocol_error("AW length, size or burst differs from the line format");
                w_addr = i_aw_addr;
                w_beat = 0;
            end
            if (w_hs)
            begin
                if (i_w_last != (w_beat == 15))
                    protocol_error("write burst last marker not on beat 16");
                mem[word_index(w_addr + w_beat * 4)] = i_w_data;
                w_beat++;
                b_pend = b_pend || i_w_last;
            end
            if (o_b_valid && i_b_ready)
                b_pend = 1'b0;
            if (r_hs)
            begin
                r_beat++;
                r_busy = !o_r_last;
            end
            #2;
            // next burst starts only once the previous one has ended
            if (!r_busy && raddr_q.size() > 0)
            begin
                r_addr = raddr_q.pop_front();
                o_r_id = rid_q.pop_front();
                r_beat = 0;
                r_busy = 1'b1;
            end
            if (!o_r_valid || r_hs)
                o_r_valid = r_busy && ($urandom_range(0, 3) != 0);
            o_r_data = mem[word_index(r_addr + r_beat * 4)];
            o_r_last = (r_beat == 15);
            if (!o_b_valid || !b_pend)
                o_b_valid = b_pend && ($urandom_range(0, 1) == 1);
            o_ar_ready = ($urandom_range(0, 3) != 0);
            o_aw_ready = ($urandom_range(0, 2) != 0);
            o_w_ready  = ($urandom_range(0, 3) != 0);
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_line_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_line_bridge;

    localparam int N_RAND  = 12;                 // operations per stream in the mixed test
    localparam int N_OPS   = 6 + 4 * N_RAND;     // upper bound on cache operations
    localparam int TIMEOUT = N_OPS * 200;

    logic                                          aclk;
    logic                                          aresetn;
    logic                                          i_i_rvalid, i_d_rvalid, i_d_wvalid;
    line_bridge_pkg::addr_t                        i_i_raddr, i_d_raddr, i_d_waddr;
    line_bridge_pkg::line_t                        i_d_wdata, o_i_rdata, o_d_rdata;
    logic                                          o_i_rready, o_d_rready, o_d_wready;
    line_bridge_pkg::axi_id_t                      o_ar_id, i_r_id;
    line_bridge_pkg::addr_t                        o_ar_addr, o_aw_addr;
    logic [line_bridge_pkg::LEN_BITS-1:0]          o_ar_len, o_aw_len;
    logic [line_bridge_pkg::SIZE_BITS-1:0]         o_ar_size, o_aw_size;
    logic [line_bridge_pkg::BURST_BITS-1:0]        o_ar_burst, o_aw_burst;
    line_bridge_pkg::beat_t                        i_r_data, o_w_data;
    logic                                          o_ar_valid, i_ar_ready;
    logic                                          i_r_last, i_r_valid, o_r_ready;
    logic                                          o_aw_valid, i_aw_ready;
    logic                                          o_w_last, o_w_valid, i_w_ready;
    logic                                          i_b_valid, o_b_ready;
    logic                                          mem_error;

    line_bridge_pkg::line_t   written [line_bridge_pkg::addr_t];  // completed writes
    line_bridge_pkg::axi_id_t ar_ids [$];                         // AR IDs in handshake order
    int                       i_reqs = 0;
    int                       d_reqs = 0;
    int                       w_reqs = 0;
    int                       i_acks = 0;
    int                       d_acks = 0;
    int                       w_acks = 0;
    int                       cycles = 0;

    line_bridge_top line_bridge_top_i (.*);

    axi_memory_model memory (
        .aclk(aclk),
        .i_ar_id(o_ar_id), .i_ar_addr(o_ar_addr), .i_ar_len(o_ar_len),
        .i_ar_size(o_ar_size), .i_ar_burst(o_ar_burst),
        .i_ar_valid(o_ar_valid), .o_ar_ready(i_ar_ready),
        .o_r_id(i_r_id), .o_r_data(i_r_data), .o_r_last(i_r_last),
        .o_r_valid(i_r_valid), .i_r_ready(o_r_ready),
        .i_aw_addr(o_aw_addr), .i_aw_len(o_aw_len), .i_aw_size(o_aw_size),
        .i_aw_burst(o_aw_burst), .i_aw_valid(o_aw_valid), .o_aw_ready(i_aw_ready),
        .i_w_data(o_w_data), .i_w_last(o_w_last), .i_w_valid(o_w_valid),
        .o_w_ready(i_w_ready), .o_b_valid(i_b_valid), .i_b_ready(o_b_ready),
        .o_error(mem_error)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    function automatic line_bridge_pkg::beat_t word_at_reset(line_bridge_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    // fill pattern unless a finished write replaced the whole line
    function automatic line_bridge_pkg::line_t expected_line(line_bridge_pkg::addr_t a);
        line_bridge_pkg::line_t l;
        if (written.exists(a))
            return written[a];
        for (int k = 0; k < line_bridge_pkg::BEATS_PER_LINE; k++)
            l[k*line_bridge_pkg::BEAT_BITS +: line_bridge_pkg::BEAT_BITS] =
                word_at_reset(a + k * 4);
        return l;
    endfunction

    function automatic line_bridge_pkg::line_t random_line();
        line_bridge_pkg::line_t l;
        for (int k = 0; k < line_bridge_pkg::BEATS_PER_LINE; k++)
            l[k*line_bridge_pkg::BEAT_BITS +: line_bridge_pkg::BEAT_BITS] = $urandom;
        return l;
    endfunction

    function automatic line_bridge_pkg::addr_t read_region_addr();
        return line_bridge_pkg::addr_t'($urandom_range(0, 127) * 64);    // lines 0..127
    endfunction

    function automatic line_bridge_pkg::addr_t write_region_addr();
        return line_bridge_pkg::addr_t'($urandom_range(128, 255) * 64);  // lines 128..255
    endfunction

    task automatic report_mismatch(string name, string got, string exp);
        $display("FAIL %0t %s got %s expected %s", $time, name, got, exp);
        $display("Finished with errors");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic check_line(string name, line_bridge_pkg::line_t got,
                              line_bridge_pkg::line_t exp);
        if (got !== exp)
            report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_id(string name, line_bridge_pkg::axi_id_t got,
                            line_bridge_pkg::axi_id_t exp);
        if (got !== exp)
            report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp)
            report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    // each request task starts and ends 2 ns after a rising edge
    task automatic icache_read(line_bridge_pkg::addr_t a);
        i_i_raddr  = a;
        i_i_rvalid = 1'b1;
        i_reqs++;
        do
        begin
            @(posedge aclk);
            #2;
        end
        while (!o_i_rready);
        i_i_rvalid = 1'b0;
    endtask

    task automatic dcache_read(line_bridge_pkg::addr_t a);
        i_d_raddr  = a;
        i_d_rvalid = 1'b1;
        d_reqs++;
        do
        begin
            @(posedge aclk);
            #2;
        end
        while (!o_d_rready);
        i_d_rvalid = 1'b0;
    endtask

    task automatic dcache_write(line_bridge_pkg::addr_t a, line_bridge_pkg::line_t l);
        i_d_waddr  = a;
        i_d_wdata  = l;
        i_d_wvalid = 1'b1;
        w_reqs++;
        do
        begin
            @(posedge aclk);
            #2;
        end
        while (!o_d_wready);
        i_d_wvalid = 1'b0;
    endtask

    // acks at 1 ns while the request is still held and AR handshakes at mid-cycle
    always
    begin
        @(posedge aclk);
        #1;
        if (o_i_rready)
        begin
            i_acks++;
            check_line("o_i_rdata", o_i_rdata, expected_line(i_i_raddr));
        end
        if (o_d_rready)
        begin
            d_acks++;
            check_line("o_d_rdata", o_d_rdata, expected_line(i_d_raddr));
        end
        if (o_d_wready)
        begin
            w_acks++;
            written[i_d_waddr] = i_d_wdata;
        end
        @(negedge aclk);
        if (o_ar_valid && i_ar_ready)
            ar_ids.push_back(o_ar_id);
    end

    always @(posedge aclk)
    begin
        cycles++;
        if (cycles > TIMEOUT)
        begin
            $display("Finished with errors");
            $fatal(1, "timeout, requests still open after %0d cycles", TIMEOUT);
        end
    end

    always @(posedge mem_error)
    begin
        $display("Finished with errors");
        $fatal(1, "memory model reported an AXI protocol error");
    end

    initial
    begin
        void'($urandom(24));
        aresetn    = 1'b0;
        i_i_rvalid = 1'b0;
        i_d_rvalid = 1'b0;
        i_d_wvalid = 1'b0;
        i_i_raddr  = '0;
        i_d_raddr  = '0;
        i_d_waddr  = '0;
        i_d_wdata  = '0;
        repeat (2) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        // idle state after reset
        check_bit("o_ar_valid", o_ar_valid, 1'b0);
        check_bit("o_aw_valid", o_aw_valid, 1'b0);
        check_bit("o_w_valid", o_w_valid, 1'b0);
        check_bit("o_b_ready", o_b_ready, 1'b0);
        check_bit("o_i_rready", o_i_rready, 1'b0);
        check_bit("o_d_rready", o_d_rready, 1'b0);
        check_bit("o_d_wready", o_d_wready, 1'b0);
        check_bit("o_r_ready", o_r_ready, 1'b1);

        ar_ids.delete();
        icache_read(32'h0000_0400);
        check_count("AR handshakes", ar_ids.size(), 1);
        check_id("o_ar_id", ar_ids[0], line_bridge_pkg::ID_ICACHE);

        // dcache goes first when both caches ask at once
        @(posedge aclk);    // icache pending flag clears a cycle after its ack
        #2;
        ar_ids.delete();
        fork
            icache_read(32'h0000_0800);
            dcache_read(32'h0000_0c00);
        join
        check_count("AR handshakes", ar_ids.size(), 2);
        check_id("o_ar_id", ar_ids[0], line_bridge_pkg::ID_DCACHE);

        dcache_write(32'h0000_0040, random_line());
        check_count("o_d_wready pulses", w_acks, w_reqs);
        dcache_read(32'h0000_0040);

        // reads and writes use disjoint regions while they overlap in time
        fork
            for (int k = 0; k < N_RAND; k++)
                icache_read(read_region_addr());
            for (int k = 0; k < N_RAND; k++)
                dcache_read(read_region_addr());
            for (int k = 0; k < N_RAND; k++)
                dcache_write(write_region_addr(), random_line());
        join
        foreach (written[a])
            icache_read(a);

        repeat (4) @(posedge aclk);
        #2;
        check_count("o_i_rready pulses", i_acks, i_reqs);
        check_count("o_d_rready pulses", d_acks, d_reqs);
        check_count("o_d_wready pulses", w_acks, w_reqs);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/line_bridge_pkg.sv
rtl/read_request_arbiter.sv
rtl/read_line_assembler.sv
rtl/write_request_issuer.sv
rtl/write_line_serializer.sv
rtl/line_bridge_top.sv
dv/axi_memory_model.sv
dv/tb_line_bridge.sv

//--- rtl/line_bridge_pkg.sv
`default_nettype none

package line_bridge_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int BEAT_BITS      = 32;
    localparam int BEATS_PER_LINE = 16;
    localparam int LINE_BITS      = BEAT_BITS * BEATS_PER_LINE;    // 512

    // axi field widths
    localparam int LEN_BITS   = 8;
    localparam int SIZE_BITS  = 3;
    localparam int BURST_BITS = 2;

    typedef logic [ADDR_BITS-1:0] addr_t;   // byte address
    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [LINE_BITS-1:0] line_t;   // beat 0 in the low word
    typedef logic [3:0]           axi_id_t;

    localparam axi_id_t ID_ICACHE = 4'd0;
    localparam axi_id_t ID_DCACHE = 4'd1;

    localparam logic [LEN_BITS-1:0]   BURST_LEN  = 8'd15;  // 16 beats
    localparam logic [SIZE_BITS-1:0]  BURST_SIZE = 3'd2;   // 4 bytes per beat
    localparam logic [BURST_BITS-1:0] BURST_INCR = 2'd1;

endpackage

`default_nettype wire

//--- rtl/line_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

module line_bridge_top (
    input  wire                                            aclk,
    input  wire                                            aresetn,
    // instruction cache read
    input  wire                                            i_i_rvalid,
    input  wire line_bridge_pkg::addr_t                    i_i_raddr,
    output logic                                           o_i_rready,
    output line_bridge_pkg::line_t                         o_i_rdata,
    // data cache read
    input  wire                                            i_d_rvalid,
    input  wire line_bridge_pkg::addr_t                    i_d_raddr,
    output logic                                           o_d_rready,
    output line_bridge_pkg::line_t                         o_d_rdata,
    // data cache write
    input  wire                                            i_d_wvalid,
    input  wire line_bridge_pkg::addr_t                    i_d_waddr,
    input  wire line_bridge_pkg::line_t                    i_d_wdata,
    output logic                                           o_d_wready,
    // axi ar
    output line_bridge_pkg::axi_id_t                       o_ar_id,
    output line_bridge_pkg::addr_t                         o_ar_addr,
    output logic [line_bridge_pkg::LEN_BITS-1:0]           o_ar_len,
    output logic [line_bridge_pkg::SIZE_BITS-1:0]          o_ar_size,
    output logic [line_bridge_pkg::BURST_BITS-1:0]         o_ar_burst,
    output logic                                           o_ar_valid,
    input  wire                                            i_ar_ready,
    // axi r
    input  wire line_bridge_pkg::axi_id_t                  i_r_id,
    input  wire line_bridge_pkg::beat_t                    i_r_data,
    input  wire                                            i_r_last,
    input  wire                                            i_r_valid,
    output logic                                           o_r_ready,
    // axi aw
    output line_bridge_pkg::addr_t                         o_aw_addr,
    output logic [line_bridge_pkg::LEN_BITS-1:0]           o_aw_len,
    output logic [line_bridge_pkg::SIZE_BITS-1:0]          o_aw_size,
    output logic [line_bridge_pkg::BURST_BITS-1:0]         o_aw_burst,
    output logic                                           o_aw_valid,
    input  wire                                            i_aw_ready,
    // axi w and b
    output line_bridge_pkg::beat_t                         o_w_data,
    output logic                                           o_w_last,
    output logic                                           o_w_valid,
    input  wire                                            i_w_ready,
    input  wire                                            i_b_valid,
    output logic                                           o_b_ready
);

    line_bridge_pkg::line_t wr_line;   // captured dirty line
    logic                   wr_start;
    logic                   wr_done;

    read_request_arbiter u_rd_arb (
        .aclk(aclk), .aresetn(aresetn),
        .i_i_rvalid(i_i_rvalid), .i_i_raddr(i_i_raddr),
        .i_d_rvalid(i_d_rvalid), .i_d_raddr(i_d_raddr),
        .i_i_done(o_i_rready), .i_d_done(o_d_rready),     // acks clear pending flags
        .o_ar_id(o_ar_id), .o_ar_addr(o_ar_addr), .o_ar_len(o_ar_len),
        .o_ar_size(o_ar_size), .o_ar_burst(o_ar_burst),
        .o_ar_valid(o_ar_valid), .i_ar_ready(i_ar_ready)
    );

    read_line_assembler u_rd_asm (
        .aclk(aclk), .aresetn(aresetn),
        .i_r_id(i_r_id), .i_r_data(i_r_data), .i_r_last(i_r_last),
        .i_r_valid(i_r_valid), .o_r_ready(o_r_ready),
        .o_i_rdata(o_i_rdata), .o_i_rready(o_i_rready),
        .o_d_rdata(o_d_rdata), .o_d_rready(o_d_rready)
    );

    write_request_issuer u_wr_iss (
        .aclk(aclk), .aresetn(aresetn),
        .i_d_wvalid(i_d_wvalid), .i_d_waddr(i_d_waddr), .i_d_wdata(i_d_wdata),
        .o_d_wready(o_d_wready),
        .o_aw_addr(o_aw_addr), .o_aw_len(o_aw_len), .o_aw_size(o_aw_size),
        .o_aw_burst(o_aw_burst), .o_aw_valid(o_aw_valid), .i_aw_ready(i_aw_ready),
        .o_b_ready(o_b_ready), .i_b_valid(i_b_valid),
        .o_line(wr_line), .o_start(wr_start), .i_done(wr_done)
    );

    write_line_serializer u_wr_ser (
        .aclk(aclk), .aresetn(aresetn),
        .i_start(wr_start), .i_line(wr_line),
        .o_w_data(o_w_data), .o_w_last(o_w_last), .o_w_valid(o_w_valid),
        .i_w_ready(i_w_ready), .o_done(wr_done)
    );

endmodule

`default_nettype wire

//--- rtl/read_line_assembler.sv
`timescale 1ns/1ns
`default_nettype none

module read_line_assembler (
    input  wire                              aclk,
    input  wire                              aresetn,
    input  wire line_bridge_pkg::axi_id_t    i_r_id,
    input  wire line_bridge_pkg::beat_t      i_r_data,
    input  wire                              i_r_last,
    input  wire                              i_r_valid,
    output logic                             o_r_ready,
    output line_bridge_pkg::line_t           o_i_rdata,
    output logic                             o_i_rready,
    output line_bridge_pkg::line_t           o_d_rdata,
    output logic                             o_d_rready
);

    // earlier beats of the burst with the oldest at the bottom
    logic [line_bridge_pkg::LINE_BITS-line_bridge_pkg::BEAT_BITS-1:0] beat_buf;
    line_bridge_pkg::line_t line_q;
    logic                   deliver_q;      // line on the outputs this cycle
    logic                   r_hs;
    logic                   r_end;

    assign o_r_ready = !deliver_q;
    assign r_hs      = i_r_valid && o_r_ready;
    assign r_end     = r_hs && i_r_last;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            deliver_q  <= 1'b0;
            o_i_rready <= 1'b0;
            o_d_rready <= 1'b0;
        end
        else
        begin
            deliver_q  <= r_end;
            o_i_rready <= r_end && (i_r_id == line_bridge_pkg::ID_ICACHE);
            o_d_rready <= r_end && (i_r_id == line_bridge_pkg::ID_DCACHE);
        end
    end

    // each burst refills the whole buffer
    always_ff @(posedge aclk)
    begin
        if (r_end)
            line_q <= {i_r_data, beat_buf};
        else if (r_hs)
            beat_buf <= {i_r_data, beat_buf[$bits(beat_buf)-1:line_bridge_pkg::BEAT_BITS]};
    end

    assign o_i_rdata = line_q;  // ack picks the owner of the shared line
    assign o_d_rdata = line_q;

endmodule

`default_nettype wire

//--- rtl/read_request_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module read_request_arbiter (
    input  wire                                            aclk,
    input  wire                                            aresetn,
    input  wire                                            i_i_rvalid,
    input  wire line_bridge_pkg::addr_t                    i_i_raddr,
    input  wire                                            i_d_rvalid,
    input  wire line_bridge_pkg::addr_t                    i_d_raddr,
    input  wire                                            i_i_done,
    input  wire                                            i_d_done,
    output line_bridge_pkg::axi_id_t                       o_ar_id,
    output line_bridge_pkg::addr_t                         o_ar_addr,
    output logic [line_bridge_pkg::LEN_BITS-1:0]           o_ar_len,
    output logic [line_bridge_pkg::SIZE_BITS-1:0]          o_ar_size,
    output logic [line_bridge_pkg::BURST_BITS-1:0]         o_ar_burst,
    output logic                                           o_ar_valid,
    input  wire                                            i_ar_ready
);

    logic i_pend;       // icache burst issued, line not yet delivered
    logic d_pend;
    logic slot_free;
    logic load_d;
    logic load_i;

    // slot frees up in the handshake cycle itself
    assign slot_free = !o_ar_valid || i_ar_ready;

    // dcache wins when both are waiting
    assign load_d = slot_free && i_d_rvalid && !d_pend;
    assign load_i = slot_free && i_i_rvalid && !i_pend && !load_d;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_ar_valid <= 1'b0;
            i_pend     <= 1'b0;
            d_pend     <= 1'b0;
        end
        else
        begin
            if (slot_free)
                o_ar_valid <= load_d || load_i;
            if (load_d)
                d_pend <= 1'b1;
            else if (i_d_done)
                d_pend <= 1'b0;     // line handed back
            if (load_i)
                i_pend <= 1'b1;
            else if (i_i_done)
                i_pend <= 1'b0;
        end
    end

    // address slot payload
    always_ff @(posedge aclk)
    begin
        if (load_d)
        begin
            o_ar_id   <= line_bridge_pkg::ID_DCACHE;
            o_ar_addr <= i_d_raddr;
        end
        else if (load_i)
        begin
            o_ar_id   <= line_bridge_pkg::ID_ICACHE;
            o_ar_addr <= i_i_raddr;
        end
    end

    assign o_ar_len   = line_bridge_pkg::BURST_LEN;
    assign o_ar_size  = line_bridge_pkg::BURST_SIZE;
    assign o_ar_burst = line_bridge_pkg::BURST_INCR;

endmodule

`default_nettype wire

//--- rtl/write_line_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module write_line_serializer (
    input  wire                              aclk,
    input  wire                              aresetn,
    input  wire                              i_start,
    input  wire line_bridge_pkg::line_t      i_line,
    output line_bridge_pkg::beat_t           o_w_data,
    output logic                             o_w_last,
    output logic                             o_w_valid,
    input  wire                              i_w_ready,
    output logic                             o_done
);

    line_bridge_pkg::line_t                               shift_q;
    logic [$clog2(line_bridge_pkg::BEATS_PER_LINE)-1:0]   beat_cnt;  // beats accepted
    logic                                                 w_hs;

    assign w_hs     = o_w_valid && i_w_ready;
    assign o_w_data = shift_q[line_bridge_pkg::BEAT_BITS-1:0];
    assign o_w_last = o_w_valid && (beat_cnt == $bits(beat_cnt)'(line_bridge_pkg::BEATS_PER_LINE - 1));

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_w_valid <= 1'b0;
            beat_cnt  <= '0;
            o_done    <= 1'b0;
        end
        else
        begin
            o_done <= w_hs && o_w_last;
            if (i_start)
            begin
                o_w_valid <= 1'b1;
                beat_cnt  <= '0;
            end
            else if (w_hs)
            begin
                beat_cnt <= beat_cnt + 1'b1;   // wraps to 0 after beat 15
                if (o_w_last)
                    o_w_valid <= 1'b0;
            end
        end
    end

    // low word goes out first
    always_ff @(posedge aclk)
    begin
        if (i_start)
            shift_q <= i_line;
        else if (w_hs)
            shift_q <= shift_q >> line_bridge_pkg::BEAT_BITS;
    end

endmodule

`default_nettype wire

//--- rtl/write_request_issuer.sv
`timescale 1ns/1ns
`default_nettype none

module write_request_issuer (
    input  wire                                            aclk,
    input  wire                                            aresetn,
    input  wire                                            i_d_wvalid,
    input  wire line_bridge_pkg::addr_t                    i_d_waddr,
    input  wire line_bridge_pkg::line_t                    i_d_wdata,
    output logic                                           o_d_wready,
    output line_bridge_pkg::addr_t                         o_aw_addr,
    output logic [line_bridge_pkg::LEN_BITS-1:0]           o_aw_len,
    output logic [line_bridge_pkg::SIZE_BITS-1:0]          o_aw_size,
    output logic [line_bridge_pkg::BURST_BITS-1:0]         o_aw_burst,
    output logic                                           o_aw_valid,
    input  wire                                            i_aw_ready,
    output logic                                           o_b_ready,
    input  wire                                            i_b_valid,
    output line_bridge_pkg::line_t                         o_line,
    output logic                                           o_start,
    input  wire                                            i_done
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } w_state_t;

    w_state_t state;
    logic     capture;

    // the ack cycle still sees the old request level, skip it
    assign capture = (state == W_IDLE) && i_d_wvalid && !o_d_wready;
    assign o_start = (state == W_ADDR) && i_aw_ready;  // serializer loads on the aw handshake

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state      <= W_IDLE;
            o_d_wready <= 1'b0;
        end
        else
        begin
            o_d_wready <= 1'b0;
            case (state)
                W_IDLE: if (capture) state <= W_ADDR;
                W_ADDR: if (i_aw_ready) state <= W_DATA;
                W_DATA: if (i_done) state <= W_RESP;
                W_RESP:
                begin
                    if (i_b_valid)
                    begin
                        state      <= W_IDLE;
                        o_d_wready <= 1'b1;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (capture)
        begin
            o_aw_addr <= i_d_waddr;
            o_line    <= i_d_wdata;
        end
    end

    assign o_aw_valid = (state == W_ADDR);
    assign o_b_ready  = (state == W_RESP);
    assign o_aw_len   = line_bridge_pkg::BURST_LEN;
    assign o_aw_size  = line_bridge_pkg::BURST_SIZE;
    assign o_aw_burst = line_bridge_pkg::BURST_INCR;

endmodule

`default_nettype wire
